// File: bus_router.f
+incdir+src
src/bus_pkg.sv
src/target_pkg.sv
src/addr_decoder.sv
src/target_port.sv
src/response_tracker.sv
src/bus_router.sv
verif/tb_clock_gen.sv
verif/bus_router_tb.sv

// File: src/addr_decoder.sv
`timescale 1ns/1ns
`default_nettype none

`include "router_params.svh"

module addr_decoder (
    input  wire bus_pkg::haddr_t         haddr,
    input  wire bus_pkg::htrans_t        htrans,
    input  wire bus_pkg::hsize_t         hsize,
    output logic                         req,
    output target_pkg::target_sel_t      target,
    output target_pkg::ram_index_t       index,
    output bus_pkg::lane_t               lanes
);

    // A master only asks for the bus with a NONSEQ transfer
    assign req = (htrans == bus_pkg::HTRANS_NONSEQ);

    // Word address, the registers take the low bits of it
    assign index = haddr[`RAM_INDEX_W+1:2];

    ////////////////////////////////////////////////////
    // Target select
    ////////////////////////////////////////////////////

    always_comb begin
        if (haddr[`MAP_SEL_HI]) begin
            target = target_pkg::TGT_REGS;
        end else if (haddr[`MAP_SEL_LO]) begin
            target = target_pkg::TGT_DATA;
        end else begin
            target = target_pkg::TGT_INST;
        end
    end

    ////////////////////////////////////////////////////
    // Byte lanes from size and offset
    ////////////////////////////////////////////////////

    always_comb begin
        case (hsize)
            bus_pkg::HSIZE_BYTE: begin
                lanes = bus_pkg::lane_t'(1) << haddr[1:0];
            end
            bus_pkg::HSIZE_HALF: begin
                // Upper or lower halfword
                lanes = haddr[1] ? 4'b1100 : 4'b0011;
            end
            default: begin
                lanes = '1;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: src/bus_pkg.sv
`default_nettype none

`include "router_params.svh"

package bus_pkg;

    // Data and address vectors of the master buses
    typedef logic [`ROUTER_DATA_W-1:0] word_t;
    typedef logic [`ROUTER_ADDR_W-1:0] haddr_t;

    // One enable bit per byte lane
    typedef logic [`ROUTER_LANES-1:0] lane_t;

    // Transfer type, only IDLE and NONSEQ are issued by the cores
    typedef enum logic [1:0] {
        HTRANS_IDLE   = 2'b00,
        HTRANS_NONSEQ = 2'b10
    } htrans_t;

    // Transfer size
    typedef enum logic [2:0] {
        HSIZE_BYTE = 3'b000,
        HSIZE_HALF = 3'b001,
        HSIZE_WORD = 3'b010
    } hsize_t;

endpackage

`default_nettype wire

// File: src/bus_router.sv
`timescale 1ns/1ns
`default_nettype none

`include "router_params.svh"

module bus_router (
    input  wire                          clk,
    input  wire                          reset,
    // Instruction fetch master
    input  wire bus_pkg::haddr_t         imem_haddr,
    input  wire bus_pkg::htrans_t        imem_htrans,
    input  wire                          imem_hwrite,
    input  wire bus_pkg::hsize_t         imem_hsize,
    input  wire bus_pkg::word_t          imem_hwdata,
    output bus_pkg::word_t               imem_hrdata,
    output logic                         imem_hready,
    // Load/store master
    input  wire bus_pkg::haddr_t         dmem_haddr,
    input  wire bus_pkg::htrans_t        dmem_htrans,
    input  wire                          dmem_hwrite,
    input  wire bus_pkg::hsize_t         dmem_hsize,
    input  wire bus_pkg::word_t          dmem_hwdata,
    output bus_pkg::word_t               dmem_hrdata,
    output logic                         dmem_hready,
    // Instruction RAM
    output target_pkg::ram_index_t       inst_addr,
    output bus_pkg::word_t               inst_write,
    output bus_pkg::lane_t               inst_wben,
    output logic                         inst_rwn,
    input  wire bus_pkg::word_t          inst_read,
    // Data RAM
    output target_pkg::ram_index_t       data_addr,
    output bus_pkg::word_t               data_write,
    output bus_pkg::lane_t               data_wben,
    output logic                         data_rwn,
    input  wire bus_pkg::word_t          data_read,
    // Register block
    output target_pkg::reg_index_t       reg_addr,
    output bus_pkg::word_t               reg_write,
    output bus_pkg::lane_t               reg_wben,
    output logic                         reg_rwn,
    input  wire bus_pkg::word_t          reg_read
);

    // Decoded requests
    logic                    imem_req;
    target_pkg::target_sel_t imem_target;
    target_pkg::ram_index_t  imem_index;
    bus_pkg::lane_t          imem_lanes;
    logic                    dmem_req;
    target_pkg::target_sel_t dmem_target;
    target_pkg::ram_index_t  dmem_index;
    bus_pkg::lane_t          dmem_lanes;

    // Grants, named target then master
    logic inst_imem_grant;
    logic inst_dmem_grant;
    logic data_imem_grant;
    logic data_dmem_grant;
    logic reg_imem_grant;
    logic reg_dmem_grant;

    logic imem_busy;
    logic dmem_busy;

    ////////////////////////////////////////////////////
    // Decode
    ////////////////////////////////////////////////////

    addr_decoder imem_dec (
        .haddr (imem_haddr),  .htrans (imem_htrans), .hsize (imem_hsize),
        .req   (imem_req),    .target (imem_target),
        .index (imem_index),  .lanes  (imem_lanes)
    );

    addr_decoder dmem_dec (
        .haddr (dmem_haddr),  .htrans (dmem_htrans), .hsize (dmem_hsize),
        .req   (dmem_req),    .target (dmem_target),
        .index (dmem_index),  .lanes  (dmem_lanes)
    );

    ////////////////////////////////////////////////////
    // Target ports
    ////////////////////////////////////////////////////

    target_port #(
        .TARGET      (target_pkg::TGT_INST),
        .FAVOR_RESET (target_pkg::MST_IMEM),
        .INDEX_W     (`RAM_INDEX_W)
    ) inst_port (
        .clk (clk), .reset (reset),
        .imem_req (imem_req), .imem_target (imem_target), .imem_index (imem_index),
        .imem_lanes (imem_lanes), .imem_hwrite (imem_hwrite),
        .imem_hwdata (imem_hwdata), .imem_busy (imem_busy),
        .dmem_req (dmem_req), .dmem_target (dmem_target), .dmem_index (dmem_index),
        .dmem_lanes (dmem_lanes), .dmem_hwrite (dmem_hwrite),
        .dmem_hwdata (dmem_hwdata), .dmem_busy (dmem_busy),
        .imem_grant (inst_imem_grant), .dmem_grant (inst_dmem_grant),
        .tgt_addr (inst_addr), .tgt_wdata (inst_write),
        .tgt_wben (inst_wben), .tgt_rwn (inst_rwn)
    );

    target_port #(
        .TARGET      (target_pkg::TGT_DATA),
        .FAVOR_RESET (target_pkg::MST_DMEM),
        .INDEX_W     (`RAM_INDEX_W)
    ) data_port (
        .clk (clk), .reset (reset),
        .imem_req (imem_req), .imem_target (imem_target), .imem_index (imem_index),
        .imem_lanes (imem_lanes), .imem_hwrite (imem_hwrite),
        .imem_hwdata (imem_hwdata), .imem_busy (imem_busy),
        .dmem_req (dmem_req), .dmem_target (dmem_target), .dmem_index (dmem_index),
        .dmem_lanes (dmem_lanes), .dmem_hwrite (dmem_hwrite),
        .dmem_hwdata (dmem_hwdata), .dmem_busy (dmem_busy),
        .imem_grant (data_imem_grant), .dmem_grant (data_dmem_grant),
        .tgt_addr (data_addr), .tgt_wdata (data_write),
        .tgt_wben (data_wben), .tgt_rwn (data_rwn)
    );

    // Register block uses the low word address bits only
    target_port #(
        .TARGET      (target_pkg::TGT_REGS),
        .FAVOR_RESET (target_pkg::MST_DMEM),
        .INDEX_W     (`REG_INDEX_W)
    ) reg_port (
        .clk (clk), .reset (reset),
        .imem_req (imem_req), .imem_target (imem_target), .imem_index (imem_index),
        .imem_lanes (imem_lanes), .imem_hwrite (imem_hwrite),
        .imem_hwdata (imem_hwdata), .imem_busy (imem_busy),
        .dmem_req (dmem_req), .dmem_target (dmem_target), .dmem_index (dmem_index),
        .dmem_lanes (dmem_lanes), .dmem_hwrite (dmem_hwrite),
        .dmem_hwdata (dmem_hwdata), .dmem_busy (dmem_busy),
        .imem_grant (reg_imem_grant), .dmem_grant (reg_dmem_grant),
        .tgt_addr (reg_addr), .tgt_wdata (reg_write),
        .tgt_wben (reg_wben), .tgt_rwn (reg_rwn)
    );

    ////////////////////////////////////////////////////
    // Responses
    ////////////////////////////////////////////////////

    response_tracker imem_resp (
        .clk (clk), .reset (reset),
        .grant_inst (inst_imem_grant), .grant_data (data_imem_grant),
        .grant_regs (reg_imem_grant),
        .inst_read (inst_read), .data_read (data_read), .reg_read (reg_read),
        .hready (imem_hready), .hrdata (imem_hrdata), .busy (imem_busy)
    );

    response_tracker dmem_resp (
        .clk (clk), .reset (reset),
        .grant_inst (inst_dmem_grant), .grant_data (data_dmem_grant),
        .grant_regs (reg_dmem_grant),
        .inst_read (inst_read), .data_read (data_read), .reg_read (reg_read),
        .hready (dmem_hready), .hrdata (dmem_hrdata), .busy (dmem_busy)
    );

endmodule

`default_nettype wire

// File: src/response_tracker.sv
`timescale 1ns/1ns
`default_nettype none

`include "router_params.svh"

module response_tracker (
    input  wire                  clk,
    input  wire                  reset,
    // Grants for this master from each target port
    input  wire                  grant_inst,
    input  wire                  grant_data,
    input  wire                  grant_regs,
    // Read data from the targets
    input  wire bus_pkg::word_t  inst_read,
    input  wire bus_pkg::word_t  data_read,
    input  wire bus_pkg::word_t  reg_read,
    output logic                 hready,
    output bus_pkg::word_t       hrdata,
    output logic                 busy
);

    typedef enum logic {
        RESP_IDLE,
        RESP_ACK
    } resp_state_t;

    resp_state_t             state;
    target_pkg::target_sel_t ack_target;

    ////////////////////////////////////////////////////
    // Ack state
    ////////////////////////////////////////////////////

    // The ack always follows a grant by one cycle
    always_ff @(posedge clk) begin
        if (reset) begin
            state      <= RESP_IDLE;
            ack_target <= target_pkg::TGT_INST;
        end else if (grant_inst || grant_data || grant_regs) begin
            state <= RESP_ACK;
            if (grant_regs) begin
                ack_target <= target_pkg::TGT_REGS;
            end else if (grant_data) begin
                ack_target <= target_pkg::TGT_DATA;
            end else begin
                ack_target <= target_pkg::TGT_INST;
            end
        end else begin
            state <= RESP_IDLE;
        end
    end

    assign hready = (state == RESP_ACK);

    // Request is still held during the ack cycle
    assign busy = (state == RESP_ACK);

    // Read data comes from the target that took the access
    always_comb begin
        case (ack_target)
            target_pkg::TGT_INST: hrdata = inst_read;
            target_pkg::TGT_DATA: hrdata = data_read;
            default:              hrdata = reg_read;
        endcase
    end

    a_one_target: assert property (@(posedge clk) disable iff (reset)
        $onehot0({grant_inst, grant_data, grant_regs}))
        else $error("response_tracker: granted by more than one target");

    a_ready_pulse: assert property (@(posedge clk) disable iff (reset)
        hready |=> !hready)
        else $error("response_tracker: hready held for two cycles");

endmodule

`default_nettype wire

// File: src/router_params.svh
`ifndef ROUTER_PARAMS_SVH
`define ROUTER_PARAMS_SVH

////////////////////////////////////////////////////
// Bus widths
////////////////////////////////////////////////////

`define ROUTER_DATA_W 32
`define ROUTER_ADDR_W 32
`define ROUTER_LANES  4

// Word index widths seen by the targets
`define RAM_INDEX_W   12
`define REG_INDEX_W   3

////////////////////////////////////////////////////
// Memory map
////////////////////////////////////////////////////

// haddr[15:14] picks the target, 1x is the register block
`define MAP_SEL_HI    15
`define MAP_SEL_LO    14

`endif

// File: src/target_pkg.sv
`default_nettype none

`include "router_params.svh"

package target_pkg;

    // Encoding follows the map select field
    typedef enum logic [1:0] {
        TGT_INST = 2'b00,
        TGT_DATA = 2'b01,
        TGT_REGS = 2'b10
    } target_sel_t;

    // Master identity, also the value of a favor bit
    typedef enum logic {
        MST_IMEM = 1'b0,
        MST_DMEM = 1'b1
    } master_id_t;

    // Word index into a RAM
    typedef logic [`RAM_INDEX_W-1:0] ram_index_t;

    // Register number in the register block
    typedef logic [`REG_INDEX_W-1:0] reg_index_t;

endpackage

`default_nettype wire

// File: src/target_port.sv
`timescale 1ns/1ns
`default_nettype none

`include "router_params.svh"

module target_port #(
    parameter target_pkg::target_sel_t TARGET      = target_pkg::TGT_INST,
    parameter target_pkg::master_id_t  FAVOR_RESET = target_pkg::MST_IMEM,
    parameter int                      INDEX_W     = `RAM_INDEX_W
) (
    input  wire                           clk,
    input  wire                           reset,
    // Instruction fetch master
    input  wire                           imem_req,
    input  wire target_pkg::target_sel_t  imem_target,
    input  wire target_pkg::ram_index_t   imem_index,
    input  wire bus_pkg::lane_t           imem_lanes,
    input  wire                           imem_hwrite,
    input  wire bus_pkg::word_t           imem_hwdata,
    input  wire                           imem_busy,
    // Load/store master
    input  wire                           dmem_req,
    input  wire target_pkg::target_sel_t  dmem_target,
    input  wire target_pkg::ram_index_t   dmem_index,
    input  wire bus_pkg::lane_t           dmem_lanes,
    input  wire                           dmem_hwrite,
    input  wire bus_pkg::word_t           dmem_hwdata,
    input  wire                           dmem_busy,
    // Grants and registered target access
    output logic                          imem_grant,
    output logic                          dmem_grant,
    output logic [INDEX_W-1:0]            tgt_addr,
    output bus_pkg::word_t                tgt_wdata,
    output bus_pkg::lane_t                tgt_wben,
    output logic                          tgt_rwn
);

    logic                   imem_want;
    logic                   dmem_want;
    logic                   conflict;
    target_pkg::master_id_t favor;

    logic [INDEX_W-1:0]     sel_index;
    bus_pkg::lane_t         sel_lanes;
    logic                   sel_hwrite;
    bus_pkg::word_t         sel_hwdata;

    ////////////////////////////////////////////////////
    // Arbitration
    ////////////////////////////////////////////////////

    // A master still waiting on its ack is not a new request
    assign imem_want = imem_req && (imem_target == TARGET) && !imem_busy;
    assign dmem_want = dmem_req && (dmem_target == TARGET) && !dmem_busy;
    assign conflict  = imem_want && dmem_want;

    assign imem_grant = imem_want && (!dmem_want || favor == target_pkg::MST_IMEM);
    assign dmem_grant = dmem_want && (!imem_want || favor == target_pkg::MST_DMEM);

    // Favor only moves when there was a real conflict
    always_ff @(posedge clk) begin
        if (reset) begin
            favor <= FAVOR_RESET;
        end else if (conflict) begin
            favor <= (favor == target_pkg::MST_IMEM) ? target_pkg::MST_DMEM
                                                     : target_pkg::MST_IMEM;
        end
    end

    // Winner's access fields
    always_comb begin
        if (dmem_grant) begin
            sel_index  = dmem_index[INDEX_W-1:0];
            sel_lanes  = dmem_lanes;
            sel_hwrite = dmem_hwrite;
            sel_hwdata = dmem_hwdata;
        end else begin
            sel_index  = imem_index[INDEX_W-1:0];
            sel_lanes  = imem_lanes;
            sel_hwrite = imem_hwrite;
            sel_hwdata = imem_hwdata;
        end
    end

    ////////////////////////////////////////////////////
    // Registered access
    ////////////////////////////////////////////////////

    // Write strobes last a single cycle per granted write
    always_ff @(posedge clk) begin
        if (reset) begin
            tgt_wben <= '0;
            tgt_rwn  <= 1'b1;
        end else if (imem_grant || dmem_grant) begin
            tgt_wben <= sel_hwrite ? sel_lanes : '0;
            tgt_rwn  <= !sel_hwrite;
        end else begin
            tgt_wben <= '0;
            tgt_rwn  <= 1'b1;
        end
    end

    // Address holds between accesses so read data stays put
    always_ff @(posedge clk) begin
        if (imem_grant || dmem_grant) begin
            tgt_addr  <= sel_index;
            tgt_wdata <= sel_hwdata;
        end
    end

    // Busy from the tracker masks a master during its ack cycle
    a_imem_no_regrant: assert property (@(posedge clk) disable iff (reset)
        imem_grant |=> !imem_grant)
        else $error("target_port: imem granted twice for one transfer");

    a_dmem_no_regrant: assert property (@(posedge clk) disable iff (reset)
        dmem_grant |=> !dmem_grant)
        else $error("target_port: dmem granted twice for one transfer");

endmodule

`default_nettype wire

// File: verif/bus_router_tb.sv
`timescale 1ns/1ns
`default_nettype none

module bus_router_tb;

    // Far above the few hundred cycles that the directed tests take
    localparam int MAX_CYCLES = 2000;
    localparam int ACK_WAIT   = 8;

    logic clk;
    logic reset;

    // Master buses
    bus_pkg::haddr_t  imem_haddr, dmem_haddr;
    bus_pkg::htrans_t imem_htrans, dmem_htrans;
    logic             imem_hwrite, dmem_hwrite;
    bus_pkg::hsize_t  imem_hsize, dmem_hsize;
    bus_pkg::word_t   imem_hwdata, dmem_hwdata;
    bus_pkg::word_t   imem_hrdata, dmem_hrdata;
    logic             imem_hready, dmem_hready;

    // Target side of the router
    target_pkg::ram_index_t inst_addr, data_addr;
    target_pkg::reg_index_t reg_addr;
    bus_pkg::word_t         inst_write, data_write, reg_write;
    bus_pkg::word_t         inst_read, data_read, reg_read;
    bus_pkg::lane_t         inst_wben, data_wben, reg_wben;
    logic                   inst_rwn, data_rwn, reg_rwn;

    bus_pkg::word_t inst_mem [0:4095];
    bus_pkg::word_t data_mem [0:4095];
    bus_pkg::word_t reg_mem  [0:7];

    integer seed;
    int     cycle_count;
    int     mismatch_count;
    int     fail_count;

    // Taken at each master's hready, index 0 is imem
    bus_pkg::word_t rdata_cap [2];
    bus_pkg::lane_t wben_cap  [2];
    logic           rwn_cap   [2];
    int             lat_cap   [2];

    tb_clock_gen clk_gen (.clk (clk), .reset (reset));

    bus_router dut0 (.*);

    ////////////////////////////////////////////////////
    // Target models
    ////////////////////////////////////////////////////

    assign inst_read = inst_mem[inst_addr];
    assign data_read = data_mem[data_addr];
    assign reg_read  = reg_mem[reg_addr];

    always @(posedge clk) begin
        for (int i = 0; i < 4; i++) begin
            if (!inst_rwn && inst_wben[i])
                inst_mem[inst_addr][8*i +: 8] <= inst_write[8*i +: 8];
            if (!data_rwn && data_wben[i])
                data_mem[data_addr][8*i +: 8] <= data_write[8*i +: 8];
            if (!reg_rwn && reg_wben[i])
                reg_mem[reg_addr][8*i +: 8] <= reg_write[8*i +: 8];
        end
    end

    task automatic report_counts();
        $display("Errors: %0d mismatches, %0d other failures", mismatch_count, fail_count);
    endtask

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count == MAX_CYCLES) begin
            $display("Timeout: tests still running after %0d cycles", MAX_CYCLES);
            report_counts();
            $display("Test FAILED");
            $finish;
        end
    end

    ////////////////////////////////////////////////////
    // Expected values from the memory map
    ////////////////////////////////////////////////////

    function automatic target_pkg::target_sel_t target_of(input bus_pkg::haddr_t a);
        if (a[15])
            return target_pkg::TGT_REGS;
        return a[14] ? target_pkg::TGT_DATA : target_pkg::TGT_INST;
    endfunction

    // Byte lanes from size and offset
    function automatic bus_pkg::lane_t expect_lanes(input bus_pkg::hsize_t size,
                                                   input logic [1:0] offset);
        if (size == bus_pkg::HSIZE_WORD)
            return 4'b1111;
        if (size == bus_pkg::HSIZE_HALF)
            return offset[1] ? 4'b1100 : 4'b0011;
        case (offset)
            2'd0:    return 4'b0001;
            2'd1:    return 4'b0010;
            2'd2:    return 4'b0100;
            default: return 4'b1000;
        endcase
    endfunction

    function automatic bus_pkg::word_t merge_bytes(input bus_pkg::word_t old_word,
            input bus_pkg::word_t new_word, input bus_pkg::lane_t lanes);
        bus_pkg::word_t result;
        result = old_word;
        for (int i = 0; i < 4; i++) begin
            if (lanes[i])
                result[8*i +: 8] = new_word[8*i +: 8];
        end
        return result;
    endfunction

    function automatic bus_pkg::word_t model_word(input bus_pkg::haddr_t a);
        case (target_of(a))
            target_pkg::TGT_INST: return inst_mem[a[13:2]];
            target_pkg::TGT_DATA: return data_mem[a[13:2]];
            default:              return reg_mem[a[4:2]];
        endcase
    endfunction

    // Random word offset inside one target window
    function automatic bus_pkg::haddr_t random_offset();
        return ($random(seed) & 32'h0000_0fff) << 2;
    endfunction

    ////////////////////////////////////////////////////
    // Compare tasks
    ////////////////////////////////////////////////////

    task automatic compare_word(input string name, input bus_pkg::word_t got,
                                input bus_pkg::word_t exp);
        if (got !== exp) begin
            $display("Mismatch %s: got %h, expected %h", name, got, exp);
            mismatch_count++;
        end
    endtask

    task automatic compare_lane(input string name, input bus_pkg::lane_t got,
                                input bus_pkg::lane_t exp);
        if (got !== exp) begin
            $display("Mismatch %s: got %h, expected %h", name, got, exp);
            mismatch_count++;
        end
    endtask

    task automatic compare_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("Mismatch %s: got %h, expected %h", name, got, exp);
            mismatch_count++;
        end
    endtask

    task automatic compare_count(input string name, input int got, input int exp);
        if (got !== exp) begin
            $display("Mismatch %s: got %h, expected %h", name, got, exp);
            mismatch_count++;
        end
    endtask

    ////////////////////////////////////////////////////
    // Master drivers
    ////////////////////////////////////////////////////

    task automatic drive_request(input target_pkg::master_id_t m, input bus_pkg::haddr_t addr,
                                 input logic write, input bus_pkg::hsize_t size,
                                 input bus_pkg::word_t wdata);
        if (m == target_pkg::MST_IMEM) begin
            imem_haddr  = addr;
            imem_hwrite = write;
            imem_hsize  = size;
            imem_hwdata = wdata;
            imem_htrans = bus_pkg::HTRANS_NONSEQ;
        end else begin
            dmem_haddr  = addr;
            dmem_hwrite = write;
            dmem_hsize  = size;
            dmem_hwdata = wdata;
            dmem_htrans = bus_pkg::HTRANS_NONSEQ;
        end
    endtask

    task automatic capture(input int m, input bus_pkg::haddr_t addr, input int n,
                           input bus_pkg::word_t rdata);
        lat_cap[m]   = n;
        rdata_cap[m] = rdata;
        case (target_of(addr))
            target_pkg::TGT_INST: begin
                wben_cap[m] = inst_wben;
                rwn_cap[m]  = inst_rwn;
            end
            target_pkg::TGT_DATA: begin
                wben_cap[m] = data_wben;
                rwn_cap[m]  = data_rwn;
            end
            default: begin
                wben_cap[m] = reg_wben;
                rwn_cap[m]  = reg_rwn;
            end
        endcase
    endtask

    // Counts cycles from the request to each master's hready
    task automatic await_acks(input bit use_i, input bit use_d);
        bit done_i;
        bit done_d;
        int n;
        done_i     = !use_i;
        done_d     = !use_d;
        n          = 0;
        lat_cap[0] = 0;
        lat_cap[1] = 0;
        while (!(done_i && done_d) && n < ACK_WAIT) begin
            @(posedge clk);
            #1;
            n++;
            // Request is dropped after the edge that took hready
            if (done_i)
                imem_htrans = bus_pkg::HTRANS_IDLE;
            if (done_d)
                dmem_htrans = bus_pkg::HTRANS_IDLE;
            if (!done_i && imem_hready) begin
                done_i = 1'b1;
                capture(0, imem_haddr, n, imem_hrdata);
            end
            if (!done_d && dmem_hready) begin
                done_d = 1'b1;
                capture(1, dmem_haddr, n, dmem_hrdata);
            end
        end
        if (!(done_i && done_d)) begin
            $display("No hready within %0d cycles of the request", ACK_WAIT);
            fail_count++;
        end
        @(posedge clk);
        #1;
        imem_htrans = bus_pkg::HTRANS_IDLE;
        dmem_htrans = bus_pkg::HTRANS_IDLE;
    endtask

    task automatic transfer(input target_pkg::master_id_t m, input bus_pkg::haddr_t addr,
                            input logic write, input bus_pkg::hsize_t size,
                            input bus_pkg::word_t wdata);
        int k;
        k = (m == target_pkg::MST_DMEM) ? 1 : 0;
        drive_request(m, addr, write, size, wdata);
        await_acks(k == 0, k == 1);
        compare_count("hready latency", lat_cap[k], 1);
        compare_lane("tgt_wben", wben_cap[k], write ? expect_lanes(size, addr[1:0]) : 4'b0000);
        compare_bit("tgt_rwn", rwn_cap[k], !write);
    endtask

    ////////////////////////////////////////////////////
    // Directed tests
    ////////////////////////////////////////////////////

    task automatic check_reset_state();
        compare_bit("imem_hready", imem_hready, 1'b0);
        compare_bit("dmem_hready", dmem_hready, 1'b0);
        compare_bit("inst_rwn", inst_rwn, 1'b1);
        compare_bit("data_rwn", data_rwn, 1'b1);
        compare_bit("reg_rwn", reg_rwn, 1'b1);
        compare_lane("inst_wben", inst_wben, 4'b0000);
        compare_lane("data_wben", data_wben, 4'b0000);
        compare_lane("reg_wben", reg_wben, 4'b0000);
    endtask

    task automatic test_word_access();
        bus_pkg::haddr_t addr;
        bus_pkg::word_t  wdata;
        for (int m = 0; m < 2; m++) begin
            for (int t = 0; t < 3; t++) begin
                addr  = (t << 14) | random_offset();
                wdata = $random(seed);
                transfer(target_pkg::master_id_t'(m), addr, 1'b1, bus_pkg::HSIZE_WORD, wdata);
                compare_word("target word", model_word(addr), wdata);
                transfer(target_pkg::master_id_t'(m), addr, 1'b0, bus_pkg::HSIZE_WORD, '0);
                compare_word("hrdata", rdata_cap[m], wdata);
            end
        end
    endtask

    // Four byte offsets, then both halfwords, masters taking turns
    task automatic test_lanes();
        bus_pkg::haddr_t        addr;
        bus_pkg::word_t         old_word;
        bus_pkg::word_t         wdata;
        bus_pkg::hsize_t        size;
        target_pkg::master_id_t m;
        for (int k = 0; k < 6; k++) begin
            m     = target_pkg::master_id_t'(k % 2);
            size  = (k < 4) ? bus_pkg::HSIZE_BYTE : bus_pkg::HSIZE_HALF;
            addr  = 32'h4000 | random_offset() | ((k < 4) ? k : (k - 4) * 2);
            wdata = $random(seed);
            transfer(m, addr & ~32'h3, 1'b0, bus_pkg::HSIZE_WORD, '0);
            old_word = rdata_cap[k % 2];
            transfer(m, addr, 1'b1, size, wdata);
            transfer(m, addr & ~32'h3, 1'b0, bus_pkg::HSIZE_WORD, '0);
            compare_word("hrdata", rdata_cap[k % 2],
                         merge_bytes(old_word, wdata, expect_lanes(size, addr[1:0])));
        end
    endtask

    task automatic test_parallel();
        bus_pkg::haddr_t ia;
        bus_pkg::haddr_t da;
        bus_pkg::word_t  wdata;
        for (int k = 0; k < 3; k++) begin
            ia    = (k << 14) | random_offset();
            da    = (((k + 1) % 3) << 14) | random_offset();
            wdata = $random(seed);
            drive_request(target_pkg::MST_IMEM, ia, 1'b0, bus_pkg::HSIZE_WORD, '0);
            drive_request(target_pkg::MST_DMEM, da, 1'b1, bus_pkg::HSIZE_WORD, wdata);
            await_acks(1'b1, 1'b1);
            compare_count("imem hready latency", lat_cap[0], 1);
            compare_count("dmem hready latency", lat_cap[1], 1);
            compare_word("imem_hrdata", rdata_cap[0], model_word(ia));
            compare_word("dmem target word", model_word(da), wdata);
        end
    endtask

    task automatic test_conflict();
        bus_pkg::haddr_t ia;
        bus_pkg::haddr_t da;
        int              winner;
        for (int t = 0; t < 3; t++) begin
            // Instruction RAM starts out favoring imem, the others dmem
            winner = (t == 0) ? 0 : 1;
            for (int r = 0; r < 3; r++) begin
                ia = (t << 14) | random_offset();
                da = (t << 14) | random_offset();
                drive_request(target_pkg::MST_IMEM, ia, 1'b0, bus_pkg::HSIZE_WORD, '0);
                drive_request(target_pkg::MST_DMEM, da, 1'b0, bus_pkg::HSIZE_WORD, '0);
                await_acks(1'b1, 1'b1);
                compare_count("winner hready latency", lat_cap[winner], 1);
                compare_count("loser hready latency", lat_cap[1 - winner], 2);
                compare_word("imem_hrdata", rdata_cap[0], model_word(ia));
                compare_word("dmem_hrdata", rdata_cap[1], model_word(da));
                winner = 1 - winner;
            end
        end
    endtask

    initial begin
        seed           = 32'h07bbea9a;
        cycle_count    = 0;
        mismatch_count = 0;
        fail_count     = 0;
        imem_haddr     = '0;
        imem_htrans    = bus_pkg::HTRANS_IDLE;
        imem_hwrite    = 1'b0;
        imem_hsize     = bus_pkg::HSIZE_WORD;
        imem_hwdata    = '0;
        dmem_haddr     = '0;
        dmem_htrans    = bus_pkg::HTRANS_IDLE;
        dmem_hwrite    = 1'b0;
        dmem_hsize     = bus_pkg::HSIZE_WORD;
        dmem_hwdata    = '0;
        for (int i = 0; i < 4096; i++) begin
            inst_mem[i] = 32'h1000_0000 | (i << 12) | i;
            data_mem[i] = 32'h2000_0000 | (i << 12) | i;
        end
        for (int i = 0; i < 8; i++) begin
            reg_mem[i] = 32'h3000_0000 | (i * 32'h0001_0101);
        end
        // Registers sampled while reset is still held
        @(posedge clk);
        #1;
        check_reset_state();
        wait (reset === 1'b0);
        @(posedge clk);
        #1;
        test_word_access();
        test_lanes();
        test_parallel();
        test_conflict();
        report_counts();
        if (mismatch_count + fail_count == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: verif/tb_clock_gen.sv
`timescale 1ns/1ns
`default_nettype none

module tb_clock_gen (
    output logic clk,
    output logic reset
);

    // 10 ns period
    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Reset held over the first two rising edges
    initial begin
        reset = 1'b1;
        repeat (2) @(posedge clk);
        #1;
        reset = 1'b0;
    end

endmodule

`default_nettype wire
